// ==== icache_pkg.sv ====
/* Instruction cache definitions */

package icache_pkg;

  // ------------------------------
  // Geometry
  // ------------------------------
  localparam int XLEN          = 32;                 // Parcel and bus data width
  localparam int PLEN          = 32;                 // Physical address width
  localparam int BLOCK_SIZE    = 16;                 // Bytes per line
  localparam int WAYS          = 2;
  localparam int SETS          = 16;

  // Address split
  localparam int BLK_OFFS_BITS = $clog2(BLOCK_SIZE);
  localparam int IDX_BITS      = $clog2(SETS);
  localparam int TAG_BITS      = PLEN - IDX_BITS - BLK_OFFS_BITS;

  // Line and burst layout
  localparam int BLK_BITS      = 8 * BLOCK_SIZE;
  localparam int BURST_SIZE    = BLK_BITS / XLEN;    // Beats per line fill
  localparam int BURST_BITS    = $clog2(BURST_SIZE);
  localparam int DAT_OFFS_BITS = $clog2(BLK_BITS / XLEN);

  // ------------------------------
  // Types
  // ------------------------------

  // Front-end FSM
  typedef enum logic [2:0] {
    ARMED,
    MISS_REQ,
    FILL,
    DELIVER,
    REPLAY
  } ctrl_state_t;

  // Request from front end to fill engine
  typedef enum logic {
    NOP,
    READ_LINE
  } fill_cmd_t;

endpackage

// ==== icache_pipe.sv ====
/* Setup and tag pipeline */

`timescale 1ns/1ps

module icache_pipe (
  input  logic                            clk_i,
  input  logic                            rst_ni,

  input  logic                            req_i,
  input  logic [icache_pkg::PLEN-1:0]     adr_i,
  input  logic                            stall_i,
  input  logic                            replay_i,

  output logic [icache_pkg::IDX_BITS-1:0] rd_idx_o,
  output logic                            tag_req_o,
  output logic [icache_pkg::PLEN-1:0]     tag_adr_o
);

  logic                        setup_req;
  logic [icache_pkg::PLEN-1:0] setup_adr;

  // Setup entry addresses the arrays
  assign rd_idx_o = setup_adr[icache_pkg::BLK_OFFS_BITS +: icache_pkg::IDX_BITS];

  // ------------------------------
  // Stage valids
  // ------------------------------
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      setup_req <= 1'b0;
      tag_req_o <= 1'b0;
    end else if (replay_i) begin
      tag_req_o <= setup_req;   // Held entry moves on
      setup_req <= 1'b0;        // CPU still stalled here
    end else if (!stall_i) begin
      tag_req_o <= setup_req;
      setup_req <= req_i;
    end
  end

  // Stage addresses
  always_ff @(posedge clk_i) begin
    if (replay_i) begin
      tag_adr_o <= setup_adr;
    end else if (!stall_i) begin
      tag_adr_o <= setup_adr;
      setup_adr <= adr_i;
    end
  end

endmodule

// ==== icache_tag_ram.sv ====
/* Tag and valid arrays */

`timescale 1ns/1ps

module icache_tag_ram (
  input  logic                            clk_i,
  input  logic                            rst_ni,

  input  logic [icache_pkg::IDX_BITS-1:0] rd_idx_i,
  input  logic                            rd_en_i,
  input  logic [icache_pkg::TAG_BITS-1:0] cmp_tag_i,
  input  logic                            invalidate_i,

  input  logic                            wr_en_i,
  input  logic [icache_pkg::IDX_BITS-1:0] wr_idx_i,
  input  logic [icache_pkg::TAG_BITS-1:0] wr_tag_i,
  input  logic [icache_pkg::WAYS-1:0]     wr_way_i,

  output logic                            hit_o,
  output logic [icache_pkg::WAYS-1:0]     hit_way_o,
  output logic [icache_pkg::WAYS-1:0]     way_valid_o    // Valid bits of the read set
);

  logic [icache_pkg::TAG_BITS-1:0] tag_mem [icache_pkg::WAYS][icache_pkg::SETS];
  logic [icache_pkg::TAG_BITS-1:0] rd_tag  [icache_pkg::WAYS];
  logic [icache_pkg::SETS-1:0]     valid_q [icache_pkg::WAYS];

  // ------------------------------
  // Valid bits
  // ------------------------------
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < icache_pkg::WAYS; w++) valid_q[w] <= '0;
      way_valid_o <= '0;
    end else begin
      for (int w = 0; w < icache_pkg::WAYS; w++) begin
        if (invalidate_i) valid_q[w] <= '0;       // Invalidate-all
        else if (wr_en_i && wr_way_i[w]) valid_q[w][wr_idx_i] <= 1'b1;

        if (rd_en_i) way_valid_o[w] <= valid_q[w][rd_idx_i];
      end
    end
  end

  // Tag storage, synchronous read
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < icache_pkg::WAYS; w++) begin
      if (wr_en_i && wr_way_i[w]) tag_mem[w][wr_idx_i] <= wr_tag_i;
      if (rd_en_i) rd_tag[w] <= tag_mem[w][rd_idx_i];
    end
  end

  // Compare against the tag stage address
  always_comb begin
    for (int w = 0; w < icache_pkg::WAYS; w++) begin
      hit_way_o[w] = way_valid_o[w] && (rd_tag[w] == cmp_tag_i);
    end
  end

  assign hit_o = |hit_way_o;

endmodule

// ==== icache_data_ram.sv ====
/* Instruction cache line storage */

`timescale 1ns/1ps

module icache_data_ram (
  input  logic                                 clk_i,

  input  logic [icache_pkg::IDX_BITS-1:0]      rd_idx_i,
  input  logic                                 rd_en_i,
  input  logic [icache_pkg::WAYS-1:0]          hit_way_i,     // One-hot
  input  logic [icache_pkg::DAT_OFFS_BITS-1:0] word_sel_i,

  input  logic                                 wr_en_i,
  input  logic [icache_pkg::IDX_BITS-1:0]      wr_idx_i,
  input  logic [icache_pkg::WAYS-1:0]          wr_way_i,
  input  logic [icache_pkg::BLK_BITS-1:0]      wr_line_i,

  output logic [icache_pkg::XLEN-1:0]          word_o
);

  logic [icache_pkg::BLK_BITS-1:0] line_mem [icache_pkg::WAYS][icache_pkg::SETS];
  logic [icache_pkg::BLK_BITS-1:0] rd_line  [icache_pkg::WAYS];
  logic [icache_pkg::BLK_BITS-1:0] sel_line;

  // Whole line written per fill
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < icache_pkg::WAYS; w++) begin
      if (wr_en_i && wr_way_i[w]) line_mem[w][wr_idx_i] <= wr_line_i;
      if (rd_en_i) rd_line[w] <= line_mem[w][rd_idx_i];
    end
  end

  // ------------------------------
  // Way then word select
  // ------------------------------
  always_comb begin
    sel_line = '0;
    for (int w = 0; w < icache_pkg::WAYS; w++) begin
      if (hit_way_i[w]) sel_line |= rd_line[w];
    end
  end

  assign word_o = sel_line[word_sel_i*icache_pkg::XLEN +: icache_pkg::XLEN];

endmodule

// ==== icache_biu_fill.sv ====
/* Line fill bus engine */

`timescale 1ns/1ps

module icache_biu_fill (
  input  logic                            clk_i,
  input  logic                            rst_ni,

  // From front end
  input  icache_pkg::fill_cmd_t           fill_cmd_i,
  input  logic [icache_pkg::PLEN-1:0]     fill_adr_i,
  output logic                            fill_done_o,
  output logic [icache_pkg::BLK_BITS-1:0] fill_line_o,
  output logic                            fill_err_o,    // Sticky over the burst

  // Bus interface
  output logic                            biu_stb_o,
  input  logic                            biu_stb_ack_i,
  output logic [icache_pkg::PLEN-1:0]     biu_adr_o,
  input  logic [icache_pkg::XLEN-1:0]     biu_q_i,
  input  logic                            biu_ack_i,
  input  logic                            biu_err_i
);

  logic                              busy_q;    // Burst accepted, beats pending
  logic [icache_pkg::BURST_BITS-1:0] beat_q;
  logic                              beat;
  logic                              start;

  assign start = fill_cmd_i == icache_pkg::READ_LINE;
  assign beat  = busy_q && (biu_ack_i || biu_err_i);  // Idle cycles just wait

  // ------------------------------
  // Handshake and beat count
  // ------------------------------
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      biu_stb_o   <= 1'b0;
      busy_q      <= 1'b0;
      beat_q      <= '0;
      fill_done_o <= 1'b0;
      fill_err_o  <= 1'b0;
    end else begin
      fill_done_o <= 1'b0;

      if (start) begin
        biu_stb_o  <= 1'b1;
        beat_q     <= '0;
        fill_err_o <= 1'b0;
      end else if (biu_stb_o && biu_stb_ack_i) begin
        biu_stb_o <= 1'b0;
        busy_q    <= 1'b1;
      end else if (beat) begin
        beat_q     <= beat_q + 1'b1;
        fill_err_o <= fill_err_o || biu_err_i;
        if (&beat_q) begin                            // Last beat
          busy_q      <= 1'b0;
          fill_done_o <= 1'b1;
        end
      end
    end
  end

  // Address and line buffer
  always_ff @(posedge clk_i) begin
    if (start) begin
      biu_adr_o <= {fill_adr_i[icache_pkg::PLEN-1:icache_pkg::BLK_OFFS_BITS],
                    {icache_pkg::BLK_OFFS_BITS{1'b0}}};
    end
    if (beat) fill_line_o[beat_q*icache_pkg::XLEN +: icache_pkg::XLEN] <= biu_q_i;
  end

endmodule

// ==== icache_ctrl.sv ====
/* Instruction cache front-end control */

`timescale 1ns/1ps

module icache_ctrl (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,

  // Tag stage
  input  logic                                 tag_req_i,
  input  logic [icache_pkg::PLEN-1:0]          tag_adr_i,
  input  logic                                 hit_i,
  input  logic [icache_pkg::WAYS-1:0]          way_valid_i,
  input  logic [icache_pkg::XLEN-1:0]          word_i,

  // Fill engine
  input  logic                                 fill_done_i,
  input  logic [icache_pkg::BLK_BITS-1:0]      fill_line_i,
  input  logic                                 fill_err_i,
  output icache_pkg::fill_cmd_t                fill_cmd_o,
  output logic [icache_pkg::PLEN-1:0]          fill_adr_o,

  output logic                                 stall_o,
  output logic                                 replay_o,

  // Array write port
  output logic                                 wr_en_o,
  output logic [icache_pkg::IDX_BITS-1:0]      wr_idx_o,
  output logic [icache_pkg::TAG_BITS-1:0]      wr_tag_o,
  output logic [icache_pkg::WAYS-1:0]          wr_way_o,
  output logic [icache_pkg::DAT_OFFS_BITS-1:0] word_sel_o,

  // Parcel out
  output logic [icache_pkg::XLEN-1:0]          parcel_o,
  output logic                                 parcel_valid_o,
  output logic                                 parcel_error_o
);

  icache_pkg::ctrl_state_t     state_q;
  logic [6:0]                  lfsr_q;       // Random way source
  logic [icache_pkg::WAYS-1:0] fill_way_q;
  logic [icache_pkg::WAYS-1:0] way_pick;
  logic                        miss;
  logic                        hit_deliver;

  assign miss        = tag_req_i && !hit_i;
  assign hit_deliver = (state_q == icache_pkg::ARMED) && tag_req_i && hit_i;

  // Hold the CPU on a fresh miss and for the whole miss sequence
  assign stall_o  = (state_q != icache_pkg::ARMED) || miss;
  assign replay_o = state_q == icache_pkg::REPLAY;

  assign fill_cmd_o = (state_q == icache_pkg::MISS_REQ) ? icache_pkg::READ_LINE
                                                        : icache_pkg::NOP;
  assign fill_adr_o = {tag_adr_i[icache_pkg::PLEN-1:icache_pkg::BLK_OFFS_BITS],
                       {icache_pkg::BLK_OFFS_BITS{1'b0}}};

  // Line written only when the burst came back clean
  assign wr_en_o    = (state_q == icache_pkg::FILL) && fill_done_i && !fill_err_i;
  assign wr_idx_o   = tag_adr_i[icache_pkg::BLK_OFFS_BITS +: icache_pkg::IDX_BITS];
  assign wr_tag_o   = tag_adr_i[icache_pkg::PLEN-1 -: icache_pkg::TAG_BITS];
  assign wr_way_o   = fill_way_q;
  assign word_sel_o = tag_adr_i[icache_pkg::BLK_OFFS_BITS-icache_pkg::DAT_OFFS_BITS +:
                                icache_pkg::DAT_OFFS_BITS];

  // Victim way, lowest invalid way wins over the LFSR
  always_comb begin
    way_pick = '0;
    way_pick[lfsr_q[$clog2(icache_pkg::WAYS)-1:0]] = 1'b1;
    for (int w = icache_pkg::WAYS-1; w >= 0; w--) begin
      if (!way_valid_i[w]) begin
        way_pick    = '0;
        way_pick[w] = 1'b1;
      end
    end
  end

  // ------------------------------
  // FSM and LFSR
  // ------------------------------
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= icache_pkg::ARMED;
      lfsr_q  <= 7'h5b;
    end else begin
      if (state_q != icache_pkg::FILL) lfsr_q <= {lfsr_q[5:0], lfsr_q[6] ^ lfsr_q[5]};

      case (state_q)
        icache_pkg::ARMED:    if (miss) state_q <= icache_pkg::MISS_REQ;
        icache_pkg::MISS_REQ: state_q <= icache_pkg::FILL;        // Command issued
        icache_pkg::FILL:     if (fill_done_i) state_q <= icache_pkg::DELIVER;
        icache_pkg::DELIVER:  state_q <= icache_pkg::REPLAY;
        icache_pkg::REPLAY:   state_q <= icache_pkg::ARMED;       // Held entry re-read
        default:              state_q <= icache_pkg::ARMED;
      endcase
    end
  end

  // ------------------------------
  // Parcel output
  // ------------------------------
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      parcel_valid_o <= 1'b0;
      parcel_error_o <= 1'b0;
    end else begin
      parcel_valid_o <= hit_deliver || (state_q == icache_pkg::DELIVER);
      parcel_error_o <= (state_q == icache_pkg::DELIVER) && fill_err_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == icache_pkg::ARMED) && miss) fill_way_q <= way_pick;

    if (state_q == icache_pkg::DELIVER) begin
      parcel_o <= fill_line_i[word_sel_o*icache_pkg::XLEN +: icache_pkg::XLEN];
    end else if (hit_deliver) begin
      parcel_o <= word_i;
    end
  end

endmodule

// ==== icache_top.sv ====
/* Instruction cache top level */

`timescale 1ns/1ps

module icache_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  // CPU side
  input  logic                        mem_req_i,
  input  logic [icache_pkg::PLEN-1:0] mem_adr_i,
  output logic                        mem_stall_o,
  output logic [icache_pkg::XLEN-1:0] parcel_o,
  output logic                        parcel_valid_o,
  output logic                        parcel_error_o,
  input  logic                        invalidate_i,

  // Bus interface
  output logic                        biu_stb_o,
  input  logic                        biu_stb_ack_i,
  output logic [icache_pkg::PLEN-1:0] biu_adr_o,
  input  logic [icache_pkg::XLEN-1:0] biu_q_i,
  input  logic                        biu_ack_i,
  input  logic                        biu_err_i
);

  logic [icache_pkg::IDX_BITS-1:0]      rd_idx;
  logic                                 rd_en;
  logic                                 tag_req;
  logic [icache_pkg::PLEN-1:0]          tag_adr;
  logic                                 hit;
  logic [icache_pkg::WAYS-1:0]          hit_way;
  logic [icache_pkg::WAYS-1:0]          way_valid;
  logic [icache_pkg::XLEN-1:0]          word;
  logic [icache_pkg::DAT_OFFS_BITS-1:0] word_sel;
  logic                                 replay;

  icache_pkg::fill_cmd_t                fill_cmd;
  logic [icache_pkg::PLEN-1:0]          fill_adr;
  logic                                 fill_done;
  logic [icache_pkg::BLK_BITS-1:0]      fill_line;
  logic                                 fill_err;

  logic                                 wr_en;
  logic [icache_pkg::IDX_BITS-1:0]      wr_idx;
  logic [icache_pkg::TAG_BITS-1:0]      wr_tag;
  logic [icache_pkg::WAYS-1:0]          wr_way;

  // Arrays track the pipe, and re-read the held entry after a fill
  assign rd_en = !mem_stall_o || replay;

  // ------------------------------
  // Setup and tag stages
  // ------------------------------
  icache_pipe pipe_inst (
    .clk_i     ( clk_i       ), .rst_ni    ( rst_ni      ),
    .req_i     ( mem_req_i   ), .adr_i     ( mem_adr_i   ),
    .stall_i   ( mem_stall_o ), .replay_i  ( replay      ),
    .rd_idx_o  ( rd_idx      ),
    .tag_req_o ( tag_req     ), .tag_adr_o ( tag_adr     )
  );

  // ------------------------------
  // Arrays
  // ------------------------------
  icache_tag_ram tag_ram_inst (
    .clk_i        ( clk_i                                          ),
    .rst_ni       ( rst_ni                                         ),
    .rd_idx_i     ( rd_idx                                         ),
    .rd_en_i      ( rd_en                                          ),
    .cmp_tag_i    ( tag_adr[icache_pkg::PLEN-1 -: icache_pkg::TAG_BITS] ),
    .invalidate_i ( invalidate_i                                   ),
    .wr_en_i      ( wr_en   ), .wr_idx_i ( wr_idx ),
    .wr_tag_i     ( wr_tag  ), .wr_way_i ( wr_way ),
    .hit_o        ( hit     ), .hit_way_o ( hit_way ),
    .way_valid_o  ( way_valid                                      )
  );

  icache_data_ram data_ram_inst (
    .clk_i      ( clk_i     ),
    .rd_idx_i   ( rd_idx    ), .rd_en_i    ( rd_en    ),
    .hit_way_i  ( hit_way   ), .word_sel_i ( word_sel ),
    .wr_en_i    ( wr_en     ), .wr_idx_i   ( wr_idx   ),
    .wr_way_i   ( wr_way    ), .wr_line_i  ( fill_line ),
    .word_o     ( word      )
  );

  // ------------------------------
  // Line fill
  // ------------------------------
  icache_biu_fill biu_fill_inst (
    .clk_i         ( clk_i         ), .rst_ni     ( rst_ni    ),
    .fill_cmd_i    ( fill_cmd      ), .fill_adr_i ( fill_adr  ),
    .biu_stb_o     ( biu_stb_o     ), .biu_adr_o  ( biu_adr_o ),
    .biu_stb_ack_i ( biu_stb_ack_i ), .biu_q_i    ( biu_q_i   ),
    .biu_ack_i     ( biu_ack_i     ), .biu_err_i  ( biu_err_i ),
    .fill_done_o   ( fill_done     ), .fill_line_o ( fill_line ),
    .fill_err_o    ( fill_err      )
  );

  // ------------------------------
  // Front end
  // ------------------------------
  icache_ctrl ctrl_inst (
    .clk_i       ( clk_i       ), .rst_ni         ( rst_ni         ),
    .tag_req_i   ( tag_req     ), .tag_adr_i      ( tag_adr        ),
    .hit_i       ( hit         ), .way_valid_i    ( way_valid      ),
    .word_i      ( word        ), .fill_done_i    ( fill_done      ),
    .fill_line_i ( fill_line   ), .fill_err_i     ( fill_err       ),
    .stall_o     ( mem_stall_o ), .replay_o       ( replay         ),
    .fill_cmd_o  ( fill_cmd    ), .fill_adr_o     ( fill_adr       ),
    .wr_en_o     ( wr_en       ), .wr_idx_o       ( wr_idx         ),
    .wr_tag_o    ( wr_tag      ), .wr_way_o       ( wr_way         ),
    .word_sel_o  ( word_sel    ), .parcel_o       ( parcel_o       ),
    .parcel_valid_o ( parcel_valid_o ),
    .parcel_error_o ( parcel_error_o )
  );

endmodule

// ==== icache_sva.sv ====
/* Cache port assertions */

`timescale 1ns/1ps

module icache_sva (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        parcel_valid_o,
  input logic        biu_stb_o,
  input logic        biu_stb_ack_i,
  input logic [31:0] biu_adr_o
);

  // Strobe and address held until the bus takes them
  property stb_held_p;
    @(posedge clk_i) disable iff (!rst_ni)
      biu_stb_o && !biu_stb_ack_i |=> biu_stb_o && $stable(biu_adr_o);
  endproperty

  property quiet_in_reset_p;
    @(posedge clk_i) !rst_ni |-> !parcel_valid_o && !biu_stb_o;
  endproperty

  property valid_known_p;
    @(posedge clk_i) disable iff (!rst_ni) !$isunknown(parcel_valid_o);
  endproperty

  stb_held_a: assert property (stb_held_p)
    else $error("biu_stb_o or biu_adr_o changed before biu_stb_ack_i");

  quiet_in_reset_a: assert property (quiet_in_reset_p)
    else $error("parcel_valid_o or biu_stb_o high during reset");

  valid_known_a: assert property (valid_known_p)
    else $error("parcel_valid_o is unknown");

endmodule

bind icache_top icache_sva sva_inst (
  .clk_i          ( clk_i          ),
  .rst_ni         ( rst_ni         ),
  .parcel_valid_o ( parcel_valid_o ),
  .biu_stb_o      ( biu_stb_o      ),
  .biu_stb_ack_i  ( biu_stb_ack_i  ),
  .biu_adr_o      ( biu_adr_o      )
);

// ==== tb_icache.sv ====
/* Instruction cache testbench */

`timescale 1ns/1ps

module tb_icache;

  localparam int          CLK_PERIOD     = 4;      // ns
  localparam int          RESET_CYCLES   = 10;
  localparam int          NUM_TESTS      = 6;
  localparam int          TEST_CYCLES    = 500;    // Upper bound per test
  localparam int          WAIT_CYCLES    = 100;    // Bound for one handshake wait
  localparam int          SEED           = 16306;
  localparam logic [31:0] MEM_PATTERN    = 32'hA5C3_0000;

  logic        clk_i;
  logic        rst_ni;
  logic        mem_req_i;
  logic [31:0] mem_adr_i;
  logic        mem_stall_o;
  logic [31:0] parcel_o;
  logic        parcel_valid_o;
  logic        parcel_error_o;
  logic        invalidate_i;
  logic        biu_stb_o;
  logic        biu_stb_ack_i;
  logic [31:0] biu_adr_o;
  logic [31:0] biu_q_i;
  logic        biu_ack_i;
  logic        biu_err_i;

  integer      seed        = SEED;
  int unsigned cyc         = 0;     // Rising edges so far
  int unsigned stb_count   = 0;
  logic [31:0] last_stb_adr;
  bit          err_en      = 1'b0;  // Error injection on err_line
  logic [31:0] err_line    = '0;

  // Requests waiting for their parcel, oldest first
  logic [31:0] exp_adr_q   [$];
  bit          exp_err_q   [$];
  bit          exp_timed_q [$];
  int unsigned acc_cyc_q   [$];

  icache_top uut (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .mem_req_i      ( mem_req_i      ),
    .mem_adr_i      ( mem_adr_i      ),
    .mem_stall_o    ( mem_stall_o    ),
    .parcel_o       ( parcel_o       ),
    .parcel_valid_o ( parcel_valid_o ),
    .parcel_error_o ( parcel_error_o ),
    .invalidate_i   ( invalidate_i   ),
    .biu_stb_o      ( biu_stb_o      ),
    .biu_stb_ack_i  ( biu_stb_ack_i  ),
    .biu_adr_o      ( biu_adr_o      ),
    .biu_q_i        ( biu_q_i        ),
    .biu_ack_i      ( biu_ack_i      ),
    .biu_err_i      ( biu_err_i      )
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) cyc <= cyc + 1;

  // Accepted strobes
  always @(posedge clk_i) begin
    if (rst_ni && biu_stb_o && biu_stb_ack_i) stb_count <= stb_count + 1;
  end

  // ------------------------------
  // Reporting
  // ------------------------------
  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR: %s is 0x%08h, expected 0x%08h", name, got, exp);
      $display("Something failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic abort_run(input string what);
    $display("Run aborted: %s", what);
    $display("Something failed");
    $fatal(1, "Aborted");
  endtask

  initial begin : watchdog
    #((NUM_TESTS * TEST_CYCLES + RESET_CYCLES) * CLK_PERIOD);
    $display("Timeout: the tests did not finish in time");
    $display("Something failed");
    $fatal(1, "Watchdog expired");
  end

  // Word at byte address a in the bus memory
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return {a[31:2], 2'b00} ^ MEM_PATTERN;
  endfunction

  // ------------------------------
  // Bus memory model
  // ------------------------------
  task automatic serve_fill();
    int unsigned delay;
    logic [31:0] line;
    check("biu_adr_o[3:0]", {28'h0, biu_adr_o[3:0]}, 32'h0);
    line  = biu_adr_o;
    delay = $unsigned($random(seed)) % 4;
    repeat (delay) @(negedge clk_i);
    biu_stb_ack_i = 1'b1;
    last_stb_adr  = line;
    @(negedge clk_i);
    biu_stb_ack_i = 1'b0;
    for (int b = 0; b < 4; b++) begin
      delay     = $unsigned($random(seed)) % 3;   // Back-pressure gap
      biu_ack_i = 1'b0;
      biu_err_i = 1'b0;
      repeat (delay) @(negedge clk_i);
      biu_q_i = mem_word(line + 4 * b);
      if (err_en && line == err_line && b == 2) biu_err_i = 1'b1;
      else biu_ack_i = 1'b1;
      @(negedge clk_i);
    end
    biu_ack_i = 1'b0;
    biu_err_i = 1'b0;
  endtask

  initial begin : bus_model
    biu_stb_ack_i = 1'b0;
    biu_q_i       = '0;
    biu_ack_i     = 1'b0;
    biu_err_i     = 1'b0;
    forever begin
      @(negedge clk_i);
      if (rst_ni && biu_stb_o) serve_fill();
    end
  end

  // Parcels are compared against the oldest open request
  always @(negedge clk_i) begin : parcel_monitor
    logic [31:0] adr;
    bit          err;
    bit          timed;
    int unsigned acc;
    if (rst_ni && parcel_valid_o) begin
      if (exp_adr_q.size() == 0) abort_run("parcel_valid_o with no request outstanding");
      adr   = exp_adr_q.pop_front();
      err   = exp_err_q.pop_front();
      timed = exp_timed_q.pop_front();
      acc   = acc_cyc_q.pop_front();
      check("parcel_error_o", {31'h0, parcel_error_o}, {31'h0, err});
      if (!err) check("parcel_o", parcel_o, mem_word(adr));
      if (timed) check("parcel latency", cyc - acc, 32'd2);   // Hit path
    end
  end

  // ------------------------------
  // Request helpers
  // ------------------------------

  // Called on a falling edge, returns on the one after the accept edge
  task automatic send_req(input logic [31:0] adr, input bit err, input bit timed);
    int unsigned n;
    mem_req_i = 1'b1;
    mem_adr_i = adr;
    n = 0;
    while (mem_stall_o) begin
      @(negedge clk_i);
      n++;
      if (n > WAIT_CYCLES) abort_run("request was never accepted");
    end
    exp_adr_q.push_back(adr);
    exp_err_q.push_back(err);
    exp_timed_q.push_back(timed);
    acc_cyc_q.push_back(cyc + 1);
    @(negedge clk_i);
  endtask

  task automatic wait_parcels();
    int unsigned n;
    mem_req_i = 1'b0;
    n = 0;
    while (exp_adr_q.size() != 0) begin
      @(posedge clk_i);
      n++;
      if (n > WAIT_CYCLES) abort_run("a parcel did not come back in time");
    end
    @(negedge clk_i);
    while (mem_stall_o) begin         // Replay still draining
      @(negedge clk_i);
      n++;
      if (n > WAIT_CYCLES) abort_run("mem_stall_o stayed high after the last parcel");
    end
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic test_cold_miss();
    int unsigned stb0;
    stb0 = stb_count;
    send_req(32'h0000_1234, 1'b0, 1'b0);
    mem_req_i = 1'b0;
    @(negedge clk_i);                 // Miss now in the tag stage
    check("mem_stall_o", {31'h0, mem_stall_o}, 32'h1);
    wait_parcels();
    check("strobe count", stb_count - stb0, 32'd1);
    check("biu_adr_o", last_stb_adr, 32'h0000_1230);
  endtask

  task automatic test_line_hits();
    int unsigned stb0;
    stb0 = stb_count;
    for (int i = 0; i < 4; i++) send_req(32'h0000_1230 + 4 * i, 1'b0, 1'b1);
    wait_parcels();
    check("strobe count", stb_count - stb0, 32'd0);
  endtask

  // Same index 5, tags 0x20 and 0x30
  task automatic test_two_ways();
    int unsigned stb0;
    stb0 = stb_count;
    send_req(32'h0000_2050, 1'b0, 1'b0);
    wait_parcels();
    send_req(32'h0000_3054, 1'b0, 1'b0);
    wait_parcels();
    check("strobe count", stb_count - stb0, 32'd2);
    stb0 = stb_count;
    send_req(32'h0000_2050, 1'b0, 1'b1);
    send_req(32'h0000_3054, 1'b0, 1'b1);
    wait_parcels();
    check("strobe count", stb_count - stb0, 32'd0);
  endtask

  task automatic test_invalidate();
    int unsigned stb0;
    invalidate_i = 1'b1;
    @(negedge clk_i);
    invalidate_i = 1'b0;
    stb0 = stb_count;
    send_req(32'h0000_1234, 1'b0, 1'b0);
    wait_parcels();
    check("strobe count", stb_count - stb0, 32'd1);
  endtask

  task automatic test_fill_error();
    int unsigned stb0;
    err_en   = 1'b1;
    err_line = 32'h0000_4070;
    stb0 = stb_count;
    send_req(32'h0000_4078, 1'b1, 1'b0);
    wait_parcels();
    err_en = 1'b0;
    send_req(32'h0000_4078, 1'b0, 1'b0);   // Line was dropped, so refetched
    wait_parcels();
    check("strobe count", stb_count - stb0, 32'd2);
  endtask

  // Two misses inside a stream of back-to-back requests
  task automatic test_stream_across_miss();
    int unsigned stb0;
    stb0 = stb_count;
    send_req(32'h0000_1230, 1'b0, 1'b0);
    send_req(32'h0000_5090, 1'b0, 1'b0);
    send_req(32'h0000_5094, 1'b0, 1'b0);
    send_req(32'h0000_1238, 1'b0, 1'b0);
    send_req(32'h0000_2054, 1'b0, 1'b0);
    send_req(32'h0000_123C, 1'b0, 1'b0);
    wait_parcels();
    check("strobe count", stb_count - stb0, 32'd2);
  endtask

  initial begin : main
    rst_ni       = 1'b0;
    mem_req_i    = 1'b0;
    mem_adr_i    = '0;
    invalidate_i = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    test_cold_miss();
    test_line_hits();
    test_two_ways();
    test_invalidate();
    test_fill_error();
    test_stream_across_miss();

    $display("Everything OK");
    $finish;
  end

endmodule

// ==== icache.f ====
icache_pkg.sv
icache_pipe.sv
icache_tag_ram.sv
icache_data_ram.sv
icache_biu_fill.sv
icache_ctrl.sv
icache_top.sv
icache_sva.sv
tb_icache.sv
